// File: logic/conv_cfg_pkg.sv
package conv_cfg_pkg;

    // Picture geometry kept small for short simulation runs
    localparam int PIC_SIZE    = 12;         // Width and height of the input picture
    localparam int KERNEL_SIZE = 5;          // Side of the square kernel
    localparam int PAD         = 2;          // Zero border on every side
    localparam int BUF_WIDTH   = PIC_SIZE + 2 * PAD; // One padded row in the line buffer
    localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;

    // Data widths
    localparam int PIXEL_BITS  = 8;
    localparam int WEIGHT_BITS = 8;

    // Full-precision sum of all taps that cannot overflow
    localparam int SUM_BITS    = PIXEL_BITS + WEIGHT_BITS + $clog2(KERNEL_TAPS);

    // Output side
    localparam int RESULT_BITS = 8;
    localparam int RESULT_MAX  = 127;        // Saturation ceiling of a result

endpackage

// File: logic/conv_types_pkg.sv
package conv_types_pkg;

    import conv_cfg_pkg::*;

    typedef logic [PIXEL_BITS-1:0]  pixel_t;
    typedef logic [WEIGHT_BITS-1:0] weight_t;

    // Tap index is row * KERNEL_SIZE + column
    typedef logic [KERNEL_TAPS-1:0][PIXEL_BITS-1:0]  window_t;
    typedef logic [KERNEL_TAPS-1:0][WEIGHT_BITS-1:0] kernel_t; // Same tap order as window_t

    typedef logic [SUM_BITS-1:0]    sum_t;    // Unsaturated PE output
    typedef logic [RESULT_BITS-1:0] result_t; // Clamped result

    typedef logic [$clog2(PIC_SIZE)-1:0]            col_t;  // Column (also used for rows)
    typedef logic [$clog2(PIC_SIZE*PIC_SIZE)-1:0]   addr_t; // Raster address of a result

endpackage

// File: logic/conv_line_if.sv
`timescale 1ns/1ps

interface conv_line_if;

    logic                line_start;   // Clear buffer and fetch the first three rows
    logic                line_advance; // Shift all rows up by one
    logic                line_load;    // With line_advance, a real row follows
    logic                line_ready;   // No fill pending
    conv_types_pkg::col_t win_col;     // Leftmost column of the window

    // Control side
    modport sequencer (
        output line_start,
        output line_advance,
        output line_load,
        output win_col,
        input  line_ready
    );

    // Storage side
    modport buffer (
        input  line_start,
        input  line_advance,
        input  line_load,
        input  win_col,
        output line_ready
    );

endinterface

// File: logic/conv_sequencer.sv
`timescale 1ns/1ps

module conv_sequencer (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     conv_start,
    input  logic     weights_full,
    input  logic     sum_valid,    // PE output valid
    conv_line_if.sequencer line,
    output logic     weight_clear,
    output logic     win_valid,
    output logic     conv_finish
);

    import conv_cfg_pkg::*;
    import conv_types_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,   // Waiting for kernel and rows
        S_COMP    // Sweeping a row and then draining the PE
    } state_t;

    state_t state;
    col_t   win_col;   // Current window column
    col_t   row_cnt;   // Output row being produced
    logic   row_done;  // Row swept and PE empty
    logic   last_row;

    // Sweep over once win_valid dropped and the last sum has left the PE
    assign row_done = (state == S_COMP) && !win_valid && !sum_valid;
    assign last_row = (row_cnt == col_t'(PIC_SIZE - 1));

    always_comb begin
        weight_clear      = (state == S_IDLE) && conv_start; // Start only taken when idle
        line.line_start   = weight_clear;
        line.line_advance = row_done && !last_row;
        // Bottom row of the next window is picture row row_cnt + 3
        line.line_load    = (int'(row_cnt) < PIC_SIZE - 3);
        line.win_col      = win_col;
        conv_finish       = row_done && last_row; // Cycle right after the last result
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            win_col   <= '0;
            row_cnt   <= '0;
            win_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (conv_start) begin
                        state   <= S_LOAD;
                        row_cnt <= '0;
                    end
                end
                S_LOAD: begin
                    // Both flags are checked a cycle after the clear so stale ones cannot pass
                    if (weights_full && line.line_ready) begin
                        state     <= S_COMP;
                        win_valid <= 1'b1;
                        win_col   <= '0;
                    end
                end
                S_COMP: begin
                    if (win_valid) begin
                        if (win_col == col_t'(PIC_SIZE - 1)) begin
                            win_valid <= 1'b0;       // Last window of the row issued
                            win_col   <= '0;
                        end else begin
                            win_col <= win_col + 1'b1;
                        end
                    end else if (!sum_valid) begin
                        if (last_row) begin
                            state <= S_IDLE;         // Finish pulse goes out this cycle
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                            state   <= S_LOAD;       // Wait for the new bottom row
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/conv_line_buffer.sv
`timescale 1ns/1ps

module conv_line_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    conv_line_if.buffer            line,
    input  conv_types_pkg::pixel_t pic,
    input  logic                   pic_valid,
    output logic                   need_pic,
    output conv_types_pkg::window_t window
);

    import conv_cfg_pkg::*;
    import conv_types_pkg::*;

    pixel_t     rows [KERNEL_SIZE][BUF_WIDTH]; // Padded rows with row 0 on top
    logic       pending;                       // A fill is in progress
    logic [2:0] fill_row;                      // Buffer row being filled
    col_t       fill_col;                      // Picture column being filled
    logic       take;                          // Pixel accepted this cycle
    logic       row_end;

    assign take      = pending && pic_valid;
    assign row_end   = (fill_col == col_t'(PIC_SIZE - 1));
    assign need_pic  = pending;
    assign line.line_ready = !pending;

    // Fill control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= 1'b0;
            fill_row <= '0;
            fill_col <= '0;
        end else if (line.line_start) begin
            pending  <= 1'b1;                  // Picture rows 0..2 go to buffer rows 2..4
            fill_row <= 3'(PAD);
            fill_col <= '0;
        end else if (line.line_advance) begin
            pending  <= line.line_load;        // No load leaves the bottom row zero
            fill_row <= 3'(KERNEL_SIZE - 1);
            fill_col <= '0;
        end else if (take) begin
            if (row_end) begin
                fill_col <= '0;
                if (fill_row == 3'(KERNEL_SIZE - 1)) begin
                    pending <= 1'b0;           // Bottom row complete
                end else begin
                    fill_row <= fill_row + 1'b1;
                end
            end else begin
                fill_col <= fill_col + 1'b1;
            end
        end
    end

    // Row storage where the border columns only ever receive zero
    always_ff @(posedge clk) begin
        if (line.line_start) begin
            for (int r = 0; r < KERNEL_SIZE; r++) begin
                for (int c = 0; c < BUF_WIDTH; c++) begin
                    rows[r][c] <= '0;
                end
            end
        end else if (line.line_advance) begin
            for (int r = 0; r < KERNEL_SIZE - 1; r++) begin
                for (int c = 0; c < BUF_WIDTH; c++) begin
                    rows[r][c] <= rows[r+1][c];
                end
            end
            for (int c = 0; c < BUF_WIDTH; c++) begin
                rows[KERNEL_SIZE-1][c] <= '0; // Overwritten by the fill when one follows
            end
        end else if (take) begin
            rows[fill_row][int'(fill_col) + PAD] <= pic;
        end
    end

    // Window columns win_col to win_col+4 in tap-major order
    always_comb begin
        for (int r = 0; r < KERNEL_SIZE; r++) begin
            for (int c = 0; c < KERNEL_SIZE; c++) begin
                window[r*KERNEL_SIZE + c] = rows[r][int'(line.win_col) + c];
            end
        end
    end

endmodule

// File: logic/conv_weight_buffer.sv
`timescale 1ns/1ps

module conv_weight_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    weight_clear,
    input  conv_types_pkg::weight_t weight_data,
    input  logic                    weight_data_valid,
    output conv_types_pkg::kernel_t kernel,
    output logic                    weights_full
);

    import conv_cfg_pkg::*;

    logic [$clog2(KERNEL_TAPS+1)-1:0] tap_cnt; // Next tap to write which stops at 25

    assign weights_full = (tap_cnt == KERNEL_TAPS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap_cnt <= '0;
        end else if (weight_clear) begin
            tap_cnt <= '0;                               // New kernel expected
        end else if (weight_data_valid && !weights_full) begin
            tap_cnt <= tap_cnt + 1'b1;
        end
    end

    // Weights kept in arrival order
    always_ff @(posedge clk) begin
        if (!weight_clear && weight_data_valid && !weights_full) begin
            kernel[tap_cnt] <= weight_data;
        end
    end

endmodule

// File: logic/conv_pe.sv
`timescale 1ns/1ps

module conv_pe (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    win_valid,
    input  conv_types_pkg::window_t window,
    input  conv_types_pkg::kernel_t kernel,
    output conv_types_pkg::sum_t    sum,
    output logic                    sum_valid
);

    import conv_cfg_pkg::*;
    import conv_types_pkg::*;

    logic [PIXEL_BITS+WEIGHT_BITS-1:0] prod [KERNEL_TAPS]; // One product per tap from stage one
    logic                              prod_valid;
    sum_t                              tree_sum;           // Combinational sum of the products

    // One valid bit per stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            sum_valid  <= 1'b0;
        end else begin
            prod_valid <= win_valid;
            sum_valid  <= prod_valid;
        end
    end

    // Stage one multiplies
    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int i = 0; i < KERNEL_TAPS; i++) begin
                prod[i] <= window[i] * kernel[i];
            end
        end
    end

    // Adder tree widened to the full sum width before adding
    always_comb begin
        tree_sum = '0;
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            tree_sum = tree_sum + sum_t'(prod[i]);
        end
    end

    // Stage two
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            sum <= tree_sum;
        end
    end

endmodule

// File: logic/conv_result_stage.sv
`timescale 1ns/1ps

module conv_result_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    conv_start,
    input  conv_types_pkg::sum_t    sum,
    input  logic                    sum_valid,
    output conv_types_pkg::result_t conv_result,
    output logic                    conv_result_valid,
    output conv_types_pkg::addr_t   conv_result_addr
);

    import conv_cfg_pkg::*;
    import conv_types_pkg::*;

    addr_t addr_cnt; // Raster position of the next result

    // Clamp in the same cycle as the PE output
    always_comb begin
        if (sum > sum_t'(RESULT_MAX)) begin
            conv_result = result_t'(RESULT_MAX);
        end else begin
            conv_result = result_t'(sum);
        end
    end

    assign conv_result_valid = sum_valid;
    assign conv_result_addr  = addr_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_cnt <= '0;
        end else if (conv_start) begin
            addr_cnt <= '0;               // Each picture restarts at 0
        end else if (sum_valid) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

endmodule

// File: logic/conv_top.sv
`timescale 1ns/1ps

module conv_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    conv_start,
    input  conv_types_pkg::pixel_t  pic,
    input  logic                    pic_valid,
    input  conv_types_pkg::weight_t weight_data,
    input  logic                    weight_data_valid,
    output logic                    need_pic,
    output conv_types_pkg::result_t conv_result,
    output logic                    conv_result_valid,
    output conv_types_pkg::addr_t   conv_result_addr,
    output logic                    conv_finish
);

    import conv_types_pkg::*;

    window_t window;       // Line buffer to PE
    kernel_t kernel;       // Weight buffer to PE
    sum_t    sum;
    logic    sum_valid;
    logic    win_valid;
    logic    weights_full;
    logic    weight_clear;

    conv_line_if line_bus ();

    conv_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .conv_start   (conv_start),
        .weights_full (weights_full),
        .sum_valid    (sum_valid),
        .line         (line_bus.sequencer),
        .weight_clear (weight_clear),
        .win_valid    (win_valid),
        .conv_finish  (conv_finish)
    );

    conv_line_buffer u_lbuf (
        .clk       (clk),
        .rst_n     (rst_n),
        .line      (line_bus.buffer),
        .pic       (pic),
        .pic_valid (pic_valid),
        .need_pic  (need_pic),
        .window    (window)
    );

    conv_weight_buffer u_wbuf (
        .clk               (clk),
        .rst_n             (rst_n),
        .weight_clear      (weight_clear),
        .weight_data       (weight_data),
        .weight_data_valid (weight_data_valid),
        .kernel            (kernel),
        .weights_full      (weights_full)
    );

    conv_pe u_pe (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .window    (window),
        .kernel    (kernel),
        .sum       (sum),
        .sum_valid (sum_valid)
    );

    conv_result_stage u_res (
        .clk               (clk),
        .rst_n             (rst_n),
        .conv_start        (conv_start),
        .sum               (sum),
        .sum_valid         (sum_valid),
        .conv_result       (conv_result),
        .conv_result_valid (conv_result_valid),
        .conv_result_addr  (conv_result_addr)
    );

endmodule

// File: dv/conv_tb_model.svh
`ifndef CONV_TB_MODEL_SVH
`define CONV_TB_MODEL_SVH

    // Reference data for one run in raster order
    int img [NPIX];          // Picture pixels
    int ker [KERNEL_TAPS];   // Kernel weights with tap = row * KERNEL_SIZE + column

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // True when this cycle should carry no valid with the rate in eighths
    function automatic bit gap_hit(inout logic [31:0] state, input int rate);
        state = xorshift32(state);
        return (int'(state[2:0]) < rate);
    endfunction

    task automatic make_picture(input int max_val, inout logic [31:0] state);
        for (int i = 0; i < NPIX; i++) begin
            state  = xorshift32(state);
            img[i] = int'(state % (max_val + 1));
        end
    endtask

    task automatic make_kernel(input int max_val, input bit centre_only,
                               inout logic [31:0] state);
        int centre;
        centre = (KERNEL_SIZE / 2) * KERNEL_SIZE + KERNEL_SIZE / 2; // Tap 12
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            state  = xorshift32(state);
            ker[i] = centre_only ? int'(i == centre) : int'(state % (max_val + 1));
        end
    endtask

    // Zero-padded 5x5 convolution at one output pixel followed by the clamp
    function automatic int expected_at(input int r, input int c);
        int acc;
        int pr;
        int pc;
        acc = 0;
        for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
            for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
                pr = r + kr - PAD;
                pc = c + kc - PAD;
                if (pr >= 0 && pr < PIC_SIZE && pc >= 0 && pc < PIC_SIZE) begin
                    acc += img[pr * PIC_SIZE + pc] * ker[kr * KERNEL_SIZE + kc];
                end
            end
        end
        return (acc > RESULT_MAX) ? RESULT_MAX : acc;
    endfunction

`endif

// File: dv/conv_tb.sv
`timescale 1ns/1ps

module conv_tb;

    import conv_cfg_pkg::*;
    import conv_types_pkg::*;

    localparam int NPIX       = PIC_SIZE * PIC_SIZE;
    localparam int NUM_TESTS  = 6;
    localparam int MAX_CYCLES = NUM_TESTS * NPIX * 4 + 200; // Watchdog limit

    typedef struct {
        string name;
        int    pix_max;     // Pixels drawn from 0..pix_max
        int    w_max;       // Weights drawn from 0..w_max
        bit    centre_only; // Identity kernel
        int    gap_rate;    // Idle eighths on both valid lines
    } test_t;

    logic    clk;
    logic    rst_n;
    logic    conv_start;
    pixel_t  pic;
    logic    pic_valid;
    weight_t weight_data;
    logic    weight_data_valid;
    logic    need_pic;
    result_t conv_result;
    logic    conv_result_valid;
    addr_t   conv_result_addr;
    logic    conv_finish;

    test_t       tests [NUM_TESTS];
    int          errors;
    int          cycles;
    logic [31:0] rng_data; // Pixel and weight values
    logic [31:0] rng_w;    // Weight valid gaps
    logic [31:0] rng_p;    // Pixel valid gaps

    `include "conv_tb_model.svh"

    conv_top dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .conv_start        (conv_start),
        .pic               (pic),
        .pic_valid         (pic_valid),
        .weight_data       (weight_data),
        .weight_data_valid (weight_data_valid),
        .need_pic          (need_pic),
        .conv_result       (conv_result),
        .conv_result_valid (conv_result_valid),
        .conv_result_addr  (conv_result_addr),
        .conv_finish       (conv_finish)
    );

    always #5 clk = ~clk; // 10 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic feed_weights(input int t);
        int k;
        k = 0;
        while (k < KERNEL_TAPS) begin
            @(posedge clk);
            #1;
            weight_data_valid = !gap_hit(rng_w, tests[t].gap_rate);
            weight_data       = weight_t'(ker[k]);
            if (weight_data_valid) begin
                k++;                                 // Stored at the next edge
            end
        end
        @(posedge clk);
        #1;
        weight_data_valid = 1'b0;
    endtask

    task automatic feed_pixels(input int t);
        int n;
        n = 0;
        while (n < NPIX) begin
            @(posedge clk);
            #1;
            pic_valid = !gap_hit(rng_p, tests[t].gap_rate);
            pic       = pixel_t'(img[n]);
            @(negedge clk);
            if (need_pic && pic_valid) begin
                n++;                                 // Taken at the coming edge
            end
        end
        @(posedge clk);
        #1;
        pic_valid = 1'b0;
    endtask

    task automatic collect_results(input int t);
        logic seen [NPIX];
        int   got;
        int   expected;
        logic prev_valid;
        logic done;
        got        = 0;
        prev_valid = 1'b0;
        done       = 1'b0;
        foreach (seen[i]) begin
            seen[i] = 1'b0;
        end
        while (!done) begin
            @(negedge clk);                          // Outputs stable mid-cycle
            if (conv_result_valid) begin
                assert (int'(conv_result_addr) < NPIX && !seen[conv_result_addr]) else begin
                    $display("%s: address %0d out of range or repeated", tests[t].name,
                             conv_result_addr);
                    errors++;
                end
                if (int'(conv_result_addr) < NPIX) begin
                    seen[conv_result_addr] = 1'b1;
                    expected = expected_at(int'(conv_result_addr) / PIC_SIZE,
                                           int'(conv_result_addr) % PIC_SIZE);
                    assert (int'(conv_result) == expected) else begin
                        $display("Error: %s addr %0d expected %0d actual %0d", tests[t].name,
                                 conv_result_addr, expected, conv_result);
                        errors++;
                    end
                end
                got++;
            end
            if (conv_finish) begin
                assert (got == NPIX && prev_valid && !conv_result_valid) else begin
                    $display("%s: finish pulse not right after the last of %0d results (%0d seen)",
                             tests[t].name, NPIX, got);
                    errors++;
                end
                assert (!need_pic) else begin
                    $display("%s: need_pic still high at finish", tests[t].name);
                    errors++;
                end
                done = 1'b1;
            end
            prev_valid = conv_result_valid;
        end
        // Engine must stay quiet until the next start
        repeat (4) begin
            @(negedge clk);
            assert (!conv_finish && !conv_result_valid && !need_pic) else begin
                $display("%s: activity after the finish pulse", tests[t].name);
                errors++;
            end
        end
    endtask

    task automatic run_test(input int t);
        int errors_before;
        errors_before = errors;
        make_picture(tests[t].pix_max, rng_data);
        make_kernel(tests[t].w_max, tests[t].centre_only, rng_data);
        @(posedge clk);
        #1;
        conv_start = 1'b1;                           // One-cycle start
        @(posedge clk);
        #1;
        conv_start = 1'b0;
        fork
            feed_weights(t);
            feed_pixels(t);
            collect_results(t);
        join
        $display("Test %0d %s: %0d errors", t, tests[t].name, errors - errors_before);
    endtask

    initial begin
        clk               = 1'b0;
        rst_n             = 1'b0;
        conv_start        = 1'b0;
        pic               = '0;
        pic_valid         = 1'b0;
        weight_data       = '0;
        weight_data_valid = 1'b0;
        errors            = 0;
        cycles            = 0;
        rng_data          = 32'hdb35d0c1;
        rng_w             = 32'hdb35d0c1 ^ 32'h5a5a5a5a;
        rng_p             = 32'hdb35d0c1 ^ 32'h3c3c3c3c;

        // name, pixel max, weight max, identity kernel, gap rate
        tests[0] = '{"zero_kernel",    255, 0,   1'b0, 0};
        tests[1] = '{"centre_tap",     127, 0,   1'b1, 0};
        tests[2] = '{"small_random",   3,   1,   1'b0, 0}; // Sum stays below 76
        tests[3] = '{"saturate",       255, 255, 1'b0, 0};
        tests[4] = '{"gapped_valid",   3,   1,   1'b0, 3};
        tests[5] = '{"restart_mixed",  255, 3,   1'b0, 2};

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!need_pic && !conv_result_valid && !conv_finish) else begin
            $display("Outputs not idle after reset");
            errors++;
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("Tests run: %0d, errors: %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: conv2d.f
+incdir+dv
logic/conv_cfg_pkg.sv
logic/conv_types_pkg.sv
logic/conv_line_if.sv
logic/conv_sequencer.sv
logic/conv_line_buffer.sv
logic/conv_weight_buffer.sv
logic/conv_pe.sv
logic/conv_result_stage.sv
logic/conv_top.sv
dv/conv_tb.sv

// File: Bender.yml
package:
  name: conv2d

sources:
  - logic/conv_cfg_pkg.sv
  - logic/conv_types_pkg.sv
  - logic/conv_line_if.sv
  - logic/conv_sequencer.sv
  - logic/conv_line_buffer.sv
  - logic/conv_weight_buffer.sv
  - logic/conv_pe.sv
  - logic/conv_result_stage.sv
  - logic/conv_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/conv_tb.sv
